// ==== logic/mem_pkg.sv ====
package mem_pkg;

    // **************************************************
    // sizes and timing
    // **************************************************

    localparam int WORD_SIZE   = 16;
    localparam int QWORD_SIZE  = 64;
    localparam int MEM_QWORDS  = 256;
    localparam int MEM_LATENCY = 4;                    // accept edge to ack cycle.
    localparam int QADDR_SIZE  = $clog2(MEM_QWORDS);   // index bits of the quad-word array.
    localparam int COUNT_SIZE  = $clog2(MEM_LATENCY);

    // **************************************************
    // data and command types
    // **************************************************

    // word address bits [1:0] pick the lane inside words.
    typedef union packed {
        logic [QWORD_SIZE-1:0]   bits;
        logic [3:0][WORD_SIZE-1:0] words;
    } qword_t;

    typedef enum logic {
        size_word  = 1'b0,
        size_qword = 1'b1
    } access_size_e;

    typedef struct packed {
        logic                 read_inst;
        logic                 read_data;
        logic                 write_data;
        access_size_e         size;
        logic [WORD_SIZE-1:0] addr_inst;
        logic [WORD_SIZE-1:0] addr_data;
        qword_t               wdata;      // a word write takes its value from words[0].
    } cpu_req_t;

    typedef struct packed {
        logic                 read;
        logic                 write;
        access_size_e         size;
        logic [WORD_SIZE-1:0] addr;
        qword_t               wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic   ready;
        logic   ack;        // one-cycle pulse, qdata valid with it.
        qword_t qdata;
    } mem_rsp_t;

endpackage

// ==== logic/request_latch.sv ====
`timescale 1ns/1ps

module request_latch
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 inst_strobe,
    input  logic [WORD_SIZE-1:0] inst_addr,
    input  logic                 data_strobe,
    input  logic                 data_write,
    input  access_size_e         data_size,
    input  logic [WORD_SIZE-1:0] data_addr,
    input  qword_t               data_wdata,
    input  logic                 ack_inst,
    input  logic                 ack_data,
    output cpu_req_t             req
);

    logic                 inst_pending;
    logic                 data_rd_pending;
    logic                 data_wr_pending;
    logic                 inst_take;
    logic                 data_take;
    logic [WORD_SIZE-1:0] addr_inst_q;
    logic [WORD_SIZE-1:0] addr_data_q;
    access_size_e         size_q;
    qword_t               wdata_q;

    assign inst_take = inst_strobe & ~inst_pending;   // a strobe on a busy client is dropped.
    assign data_take = data_strobe & ~(data_rd_pending | data_wr_pending);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            inst_pending    <= 1'b0;
            data_rd_pending <= 1'b0;
            data_wr_pending <= 1'b0;
        end else begin
            if (inst_take) begin
                inst_pending <= 1'b1;
            end else if (ack_inst) begin
                inst_pending <= 1'b0;
            end
            if (data_take) begin
                data_rd_pending <= ~data_write;
                data_wr_pending <= data_write;
            end else if (ack_data) begin
                data_rd_pending <= 1'b0;
                data_wr_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_take) begin
            addr_inst_q <= inst_addr;
        end
        if (data_take) begin
            addr_data_q <= data_addr;
            size_q      <= data_size;
            wdata_q     <= data_wdata;
        end
    end

    always_comb begin
        req            = '0;
        req.read_inst  = inst_pending;
        req.read_data  = data_rd_pending;
        req.write_data = data_wr_pending;
        req.size       = size_q;
        req.addr_inst  = addr_inst_q;
        req.addr_data  = addr_data_q;
        req.wdata      = wdata_q;
    end

endmodule

// ==== logic/memory_io.sv ====
`timescale 1ns/1ps

module memory_io
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  cpu_req_t req,
    input  logic     is_granted,
    input  mem_rsp_t rsp1,
    input  mem_rsp_t rsp2,
    output mem_cmd_t cmd1,
    output mem_cmd_t cmd2,
    output qword_t   res_inst,
    output qword_t   res_data,
    output logic     ack_inst,
    output logic     ack_data
);

    logic                 p1_read;
    logic                 p2_read;
    logic                 p2_write;
    logic [WORD_SIZE-1:0] p1_addr;
    logic [WORD_SIZE-1:0] p2_addr;
    access_size_e         p2_size;
    qword_t               p2_wdata;

    logic m1_data;      // high when the data client owns port 1.
    logic m2_data;      // high when the data client owns port 2.
    logic inst_busy;
    logic data_busy;

    logic m1_free;
    logic m2_free;
    logic inst_want;
    logic data_want;
    logic issue_inst_p1;
    logic issue_inst_p2;
    logic issue_data_p1;
    logic issue_data_p2;
    logic inst_on_p1;
    logic data_on_p1;

    // **************************************************
    // routing
    // **************************************************

    // a port is free only once its previous command has been cleared.
    assign m1_free = rsp1.ready & ~p1_read;
    assign m2_free = rsp2.ready & is_granted & ~p2_read & ~p2_write;

    assign inst_want = req.read_inst & ~inst_busy;
    assign data_want = (req.read_data | req.write_data) & ~data_busy;

    // data has first claim on port 2 and writes never leave it.
    assign issue_data_p2 = data_want & m2_free;
    assign issue_data_p1 = data_want & req.read_data & ~m2_free & m1_free & ~req.read_inst;
    assign issue_inst_p1 = inst_want & m1_free;
    assign issue_inst_p2 = inst_want & ~m1_free & m2_free & ~req.read_data & ~issue_data_p2;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            p1_read   <= 1'b0;
            p2_read   <= 1'b0;
            p2_write  <= 1'b0;
            m1_data   <= 1'b0;
            m2_data   <= 1'b1;
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
        end else begin
            if (rsp1.ack) begin
                p1_read <= 1'b0;
            end
            if (rsp2.ack) begin
                p2_read  <= 1'b0;
                p2_write <= 1'b0;
            end
            if (issue_inst_p1 | issue_data_p1) begin
                p1_read <= 1'b1;
                m1_data <= issue_data_p1;
            end
            if (issue_inst_p2 | issue_data_p2) begin
                p2_read  <= issue_inst_p2 | (issue_data_p2 & req.read_data);
                p2_write <= issue_data_p2 & req.write_data;
                m2_data  <= issue_data_p2;
            end
            if (ack_inst) begin
                inst_busy <= 1'b0;
            end else if (issue_inst_p1 | issue_inst_p2) begin
                inst_busy <= 1'b1;
            end
            if (ack_data) begin
                data_busy <= 1'b0;
            end else if (issue_data_p1 | issue_data_p2) begin
                data_busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_inst_p1 | issue_data_p1) begin
            p1_addr <= issue_data_p1 ? req.addr_data : req.addr_inst;
        end
        if (issue_inst_p2 | issue_data_p2) begin
            p2_addr <= issue_data_p2 ? req.addr_data : req.addr_inst;
        end
        if (issue_data_p2) begin
            p2_size  <= req.size;
            p2_wdata <= req.wdata;
        end
    end

    always_comb begin
        cmd1       = '0;
        cmd1.read  = p1_read;
        cmd1.addr  = p1_addr;
        cmd2       = '0;
        cmd2.read  = p2_read;
        cmd2.write = p2_write;
        cmd2.size  = p2_size;
        cmd2.addr  = p2_addr;
        cmd2.wdata = p2_wdata;
    end

    // **************************************************
    // result steering
    // **************************************************

    assign inst_on_p1 = rsp1.ack & ~m1_data;
    assign data_on_p1 = rsp1.ack & m1_data;

    assign ack_inst = inst_on_p1 | (rsp2.ack & ~m2_data);
    assign ack_data = data_on_p1 | (rsp2.ack & m2_data);
    assign res_inst = inst_on_p1 ? rsp1.qdata : rsp2.qdata;
    assign res_data = data_on_p1 ? rsp1.qdata : rsp2.qdata;

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic clk,
    input  logic reset_n,
    input  logic dma_req,
    input  logic m2_idle,
    output logic is_granted,
    output logic dma_grant
);

    logic dma_owner;
    logic take_bus;
    logic give_back;

    // ownership only moves while port 2 has nothing in flight.
    assign take_bus  = ~dma_owner & dma_req & m2_idle;
    assign give_back = dma_owner & ~dma_req & m2_idle;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            dma_owner <= 1'b0;
        end else if (take_bus) begin
            dma_owner <= 1'b1;
        end else if (give_back) begin
            dma_owner <= 1'b0;
        end
    end

    // the grant to the router drops in the handover cycle itself.
    assign is_granted = ~dma_owner & ~take_bus;   // so no new command starts as the DMA takes over.
    assign dma_grant  = dma_owner;

endmodule

// ==== logic/dual_port_memory.sv ====
`timescale 1ns/1ps

module dual_port_memory
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  mem_cmd_t cmd1,
    input  mem_cmd_t cmd2,
    output mem_rsp_t rsp1,
    output mem_rsp_t rsp2
);

    qword_t mem [MEM_QWORDS];

    mem_cmd_t              cmd_in [2];
    mem_cmd_t              cmd_q  [2];
    mem_rsp_t              rsp    [2];
    logic                  busy   [2];
    logic [COUNT_SIZE-1:0] count  [2];
    logic [1:0]            accept;
    logic [1:0]            ack;

    logic [QADDR_SIZE-1:0] wr_index;
    logic [1:0]            wr_lane;

    always_comb begin
        cmd_in[0]       = cmd1;
        cmd_in[0].write = 1'b0;   // port 1 has no write path.
        cmd_in[1]       = cmd2;
    end

    // **************************************************
    // per-port latency pipeline
    // **************************************************

    for (genvar p = 0; p < 2; p++) begin : g_port
        assign accept[p] = ~busy[p] & (cmd_in[p].read | cmd_in[p].write);
        assign ack[p]    = busy[p] & (count[p] == '0);

        always_ff @(posedge clk) begin
            if (!reset_n) begin
                busy[p]  <= 1'b0;
                count[p] <= '0;
            end else if (accept[p]) begin
                busy[p]  <= 1'b1;
                count[p] <= COUNT_SIZE'(MEM_LATENCY - 1);
            end else if (ack[p]) begin
                busy[p] <= 1'b0;
            end else if (busy[p]) begin
                count[p] <= count[p] - 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (accept[p]) begin
                cmd_q[p] <= cmd_in[p];
            end
        end

        // address bits above the array size alias onto it.
        assign rsp[p].ready = ~busy[p];
        assign rsp[p].ack   = ack[p];
        assign rsp[p].qdata = mem[cmd_q[p].addr[QADDR_SIZE+1:2]];
    end

    assign rsp1 = rsp[0];
    assign rsp2 = rsp[1];

    // **************************************************
    // port 2 write at the ack edge
    // **************************************************

    assign wr_index = cmd_q[1].addr[QADDR_SIZE+1:2];
    assign wr_lane  = cmd_q[1].addr[1:0];

    always_ff @(posedge clk) begin
        if (ack[1] && cmd_q[1].write) begin
            if (cmd_q[1].size == size_qword) begin
                mem[wr_index] <= cmd_q[1].wdata;
            end else begin
                mem[wr_index].words[wr_lane] <= cmd_q[1].wdata.words[0];   // other lanes are kept.
            end
        end
    end

endmodule

// ==== logic/mem_system.sv ====
`timescale 1ns/1ps

module mem_system
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 inst_strobe,
    input  logic [WORD_SIZE-1:0] inst_addr,
    input  logic                 data_strobe,
    input  logic                 data_write,
    input  access_size_e         data_size,
    input  logic [WORD_SIZE-1:0] data_addr,
    input  qword_t               data_wdata,
    input  logic                 dma_req,
    output qword_t               res_inst,
    output qword_t               res_data,
    output logic                 ack_inst,
    output logic                 ack_data,
    output logic                 dma_grant
);

    cpu_req_t req;
    mem_cmd_t cmd1;
    mem_cmd_t cmd2;
    mem_rsp_t rsp1;
    mem_rsp_t rsp2;
    logic     is_granted;
    logic     m2_idle;

    assign m2_idle = rsp2.ready & ~cmd2.read & ~cmd2.write;

    request_latch request_latch_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst_strobe (inst_strobe),
        .inst_addr   (inst_addr),
        .data_strobe (data_strobe),
        .data_write  (data_write),
        .data_size   (data_size),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .ack_inst    (ack_inst),
        .ack_data    (ack_data),
        .req         (req)
    );

    memory_io memory_io_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .req        (req),
        .is_granted (is_granted),
        .rsp1       (rsp1),
        .rsp2       (rsp2),
        .cmd1       (cmd1),
        .cmd2       (cmd2),
        .res_inst   (res_inst),
        .res_data   (res_data),
        .ack_inst   (ack_inst),
        .ack_data   (ack_data)
    );

    bus_arbiter bus_arbiter_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .dma_req    (dma_req),
        .m2_idle    (m2_idle),
        .is_granted (is_granted),
        .dma_grant  (dma_grant)
    );

    dual_port_memory dual_port_memory_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .cmd1    (cmd1),
        .cmd2    (cmd2),
        .rsp1    (rsp1),
        .rsp2    (rsp2)
    );

endmodule

// ==== tb/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// shadow copy of the memory, one entry per quad word.
qword_t shadow [MEM_QWORDS];

// the quad word sits at addr[WORD_SIZE-1:2], folded onto the array depth.
function automatic int shadow_index(input logic [WORD_SIZE-1:0] addr);
    return int'(addr[WORD_SIZE-1:2]) % MEM_QWORDS;
endfunction

function automatic qword_t ref_read_qword(input logic [WORD_SIZE-1:0] addr);
    return shadow[shadow_index(addr)];
endfunction

// a word write replaces the lane picked by addr[1:0] with words[0] of the data.
function automatic void ref_write(
    input access_size_e         size,
    input logic [WORD_SIZE-1:0] addr,
    input qword_t               wdata
);
    int     idx;
    qword_t q;
    idx = shadow_index(addr);
    q   = shadow[idx];
    if (size == size_qword) begin
        q = wdata;
    end else begin
        q.words[addr[1:0]] = wdata.words[0];
    end
    shadow[idx] = q;
endfunction

`endif

// ==== tb/tb_mem_system.sv ====
`timescale 1ns/1ps

module tb_mem_system
    import mem_pkg::*;
();

    localparam int SEED       = 9;
    localparam int NUM_TESTS  = 5;
    localparam int NUM_OPS    = 32;                       // most operations in any one test.
    localparam int NUM_ADDRS  = 16;
    localparam int ACK_CYCLES = 4 * (MEM_LATENCY + 2);
    localparam int TIMEOUT_NS = NUM_TESTS * NUM_OPS * (MEM_LATENCY + 2) * 8 * 4;

    typedef struct packed {
        logic                 write;
        access_size_e         size;
        logic [WORD_SIZE-1:0] addr;
        qword_t               wdata;
    } data_op_t;

    logic                 clk;
    logic                 reset_n;
    logic                 inst_strobe;
    logic [WORD_SIZE-1:0] inst_addr;
    logic                 data_strobe;
    logic                 data_write;
    access_size_e         data_size;
    logic [WORD_SIZE-1:0] data_addr;
    qword_t               data_wdata;
    logic                 dma_req;
    qword_t               res_inst;
    qword_t               res_data;
    logic                 ack_inst;
    logic                 ack_data;
    logic                 dma_grant;

    logic [WORD_SIZE-1:0] inst_q [$];    // addresses of outstanding instruction reads.
    data_op_t             data_q [$];
    logic [WORD_SIZE-1:0] addrs [NUM_ADDRS];
    int                   errors    = 0;
    int                   checks    = 0;
    int                   tests_run = 0;
    int                   inst_acks = 0;
    int                   data_acks = 0;

    `include "tb_ref.svh"

    mem_system mem_system_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst_strobe (inst_strobe),
        .inst_addr   (inst_addr),
        .data_strobe (data_strobe),
        .data_write  (data_write),
        .data_size   (data_size),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .dma_req     (dma_req),
        .res_inst    (res_inst),
        .res_data    (res_data),
        .ack_inst    (ack_inst),
        .ack_data    (ack_data),
        .dma_grant   (dma_grant)
    );

    always #4 clk = ~clk;

    // **************************************************
    // comparison against the shadow memory
    // **************************************************

    always @(posedge clk) begin
        logic [WORD_SIZE-1:0] a;
        data_op_t             op;
        if (ack_inst) begin
            inst_acks++;
            if (inst_q.size() == 0) begin
                $display("Error: %0t an instruction ack came with no read outstanding", $time);
                errors++;
            end else begin
                a = inst_q.pop_front();
                checks++;
                assert (res_inst === ref_read_qword(a)) else begin
                    $display("Error: %0t res_inst expected %h got %h",
                             $time, ref_read_qword(a), res_inst);
                    errors++;
                end
            end
        end
        if (ack_data) begin
            data_acks++;
            if (data_q.size() == 0) begin
                $display("Error: %0t a data ack came with no request outstanding", $time);
                errors++;
            end else begin
                op = data_q.pop_front();
                if (op.write) begin
                    ref_write(op.size, op.addr, op.wdata);   // the DUT stores at this edge too.
                end else begin
                    checks++;
                    assert (res_data === ref_read_qword(op.addr)) else begin
                        $display("Error: %0t res_data expected %h got %h",
                                 $time, ref_read_qword(op.addr), res_data);
                        errors++;
                    end
                end
            end
        end
    end

    // **************************************************
    // stimulus helpers
    // **************************************************

    function automatic qword_t random_qword();
        qword_t q;
        q.bits = {$urandom(), $urandom()};
        return q;
    endfunction

    function automatic data_op_t make_op(
        input logic                 write,
        input access_size_e         size,
        input logic [WORD_SIZE-1:0] addr,
        input qword_t               wdata
    );
        data_op_t op;
        op.write = write;
        op.size  = size;
        op.addr  = addr;
        op.wdata = wdata;
        return op;
    endfunction

    task automatic strobe_requests(
        input logic                 do_inst,
        input logic [WORD_SIZE-1:0] iaddr,
        input logic                 do_data,
        input data_op_t             op
    );
        @(negedge clk);
        inst_strobe = do_inst;
        inst_addr   = iaddr;
        data_strobe = do_data;
        data_write  = op.write;
        data_size   = op.size;
        data_addr   = op.addr;
        data_wdata  = op.wdata;
        if (do_inst) begin
            inst_q.push_back(iaddr);
        end
        if (do_data) begin
            data_q.push_back(op);
        end
        @(negedge clk);
        inst_strobe = 1'b0;
        data_strobe = 1'b0;
    endtask

    task automatic wait_acks(input int inst_target, input int data_target, input string what);
        int n;
        n = 0;
        while ((inst_acks < inst_target || data_acks < data_target) && n < ACK_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (inst_acks < inst_target || data_acks < data_target) begin
            $display("Error: %0t no ack arrived for %s", $time, what);
            errors++;
        end
    endtask

    task automatic data_access(input data_op_t op);
        int target;
        target = data_acks + 1;
        strobe_requests(1'b0, '0, 1'b1, op);
        wait_acks(inst_acks, target, "a data request");
    endtask

    task automatic inst_access(input logic [WORD_SIZE-1:0] addr);
        int target;
        target = inst_acks + 1;
        strobe_requests(1'b1, addr, 1'b0, '0);
        wait_acks(target, data_acks, "an instruction read");
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("test %0d %s done with %0d errors", tests_run, name, errors - errors_before);
    endtask

    // **************************************************
    // test sequence
    // **************************************************

    initial begin
        int                   mark;
        int                   n;
        int                   ii;
        int                   di;
        int                   target;
        logic [WORD_SIZE-1:0] a;
        qword_t               q;
        void'($urandom(SEED));
        clk         = 1'b0;
        reset_n     = 1'b0;
        inst_strobe = 1'b0;
        inst_addr   = '0;
        data_strobe = 1'b0;
        data_write  = 1'b0;
        data_size   = size_qword;
        data_addr   = '0;
        data_wdata  = '0;
        dma_req     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        mark = errors;
        for (int i = 0; i < NUM_ADDRS; i++) begin
            addrs[i] = 16'($urandom());
            data_access(make_op(1'b1, size_qword, addrs[i], random_qword()));
        end
        for (int i = 0; i < NUM_ADDRS; i++) begin
            data_access(make_op(1'b0, size_qword, addrs[i], '0));
        end
        report_test("quad-word writes", mark);

        mark = errors;
        a = {addrs[0][WORD_SIZE-1:2], 2'b00};
        for (int lane = 0; lane < 4; lane++) begin
            q = random_qword();                       // upper lanes must be ignored.
            data_access(make_op(1'b1, size_word, a | 16'(lane), q));
            data_access(make_op(1'b0, size_qword, a, '0));
        end
        report_test("word writes", mark);

        mark = errors;
        for (int i = 0; i < NUM_ADDRS; i++) begin
            inst_access(addrs[i]);
        end
        report_test("instruction reads", mark);

        mark = errors;
        for (int i = 0; i < NUM_ADDRS; i++) begin
            ii = int'($urandom_range(NUM_ADDRS - 1));
            di = int'($urandom_range(NUM_ADDRS - 1));
            n  = inst_acks + 1;
            target = data_acks + 1;
            strobe_requests(1'b1, addrs[ii], 1'b1, make_op(1'b0, size_qword, addrs[di], '0));
            wait_acks(n, target, "a concurrent instruction and data read");
        end
        report_test("concurrent requests", mark);

        mark = errors;
        @(negedge clk);
        dma_req = 1'b1;
        n = 0;
        while (!dma_grant && n < ACK_CYCLES) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (dma_grant === 1'b1) else begin
            $display("Error: %0t dma_grant expected 1 got %b", $time, dma_grant);
            errors++;
        end
        // with port 2 held by the DMA this read is served on port 1.
        data_access(make_op(1'b0, size_qword, addrs[1], '0));
        a = 16'($urandom());
        target = data_acks + 1;
        strobe_requests(1'b0, '0, 1'b1, make_op(1'b1, size_qword, a, random_qword()));
        repeat (ACK_CYCLES) @(negedge clk);
        checks++;
        assert (data_acks == target - 1) else begin
            $display("Error: %0t a data write was acknowledged while the DMA held the bus",
                     $time);
            errors++;
        end
        dma_req = 1'b0;
        wait_acks(inst_acks, target, "the data write held back by the DMA");
        checks++;
        assert (dma_grant === 1'b0) else begin
            $display("Error: %0t dma_grant expected 0 got %b", $time, dma_grant);
            errors++;
        end
        data_access(make_op(1'b0, size_qword, a, '0));
        report_test("DMA ownership", mark);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with the tests still running", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tb
logic/mem_pkg.sv
logic/request_latch.sv
logic/memory_io.sv
logic/bus_arbiter.sv
logic/dual_port_memory.sv
logic/mem_system.sv
tb/tb_mem_system.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_mem_system
RTL_TOP   = mem_system
FILELIST  = vlog.f
SIM       = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
